// File: logic/uart_pkg.sv
package uart_pkg;

   // One serial data byte
   typedef logic [7:0] byte_t;

   // Index of a data bit inside the frame
   typedef logic [2:0] bit_idx_t;

   // Start, eight data bits, stop
   localparam int FRAME_BITS = 10;
   localparam int DATA_BITS = FRAME_BITS - 2;

   // Index of the last data bit since the LSB goes first
   localparam bit_idx_t LAST_BIT = bit_idx_t'(DATA_BITS - 1);

   // Line levels
   localparam logic LINE_IDLE = 1'b1;
   localparam logic START_LEVEL = 1'b0;
   localparam logic STOP_LEVEL = 1'b1;

   // Frame phases shared by both directions
   typedef enum logic [1:0] {
      SER_IDLE,
      SER_START,
      SER_DATA,
      SER_STOP
   } ser_state_e;

endpackage

// File: logic/report_pkg.sv
package report_pkg;

   // Widest data word a report can carry
   localparam int REPORT_DATA_MAX = 32;

   typedef logic [REPORT_DATA_MAX-1:0] report_data_t;
   typedef logic [1:0] reg_id_t;

   // One report from the client
   typedef struct packed {
      reg_id_t reg_id;
      report_data_t data;
   } report_t;

   // ASCII character that also fills a FIFO entry
   typedef logic [7:0] char_t;

   // One hex digit
   typedef logic [3:0] nibble_t;

   // Walk through one output line
   typedef enum logic [2:0] {
      FMT_IDLE,
      FMT_R,
      FMT_ID,
      FMT_COLON,
      FMT_HEX,
      FMT_LF,
      FMT_CR
   } fmt_state_e;

   localparam char_t ASCII_R = 8'h52;
   localparam char_t ASCII_COLON = 8'h3A;
   localparam char_t ASCII_LF = 8'h0A;
   localparam char_t ASCII_CR = 8'h0D;

   // Bases for the hex digits
   localparam char_t ASCII_0 = 8'h30;
   localparam char_t ASCII_A = 8'h41;

endpackage

// File: logic/report_formatter.sv
`timescale 1ns/1ps

module report_formatter
   import report_pkg::*;
#(
   parameter int NUM_NIBBLES = 4
) (
   input  logic    clk,
   input  logic    rst,
   input  report_t i_rep,
   input  logic    i_rep_valid,
   output logic    o_rep_ready,
   output char_t   o_chr,
   output logic    o_chr_valid,
   input  logic    i_chr_ready,
   output logic    o_idle
);

   // Enough to count down from NUM_NIBBLES-1
   typedef logic [$clog2(REPORT_DATA_MAX / 4)-1:0] nib_cnt_t;

   // Bit position of the first printed nibble
   localparam int TOP_BIT = 4 * NUM_NIBBLES - 1;
   localparam nib_cnt_t NIB_FIRST = nib_cnt_t'(NUM_NIBBLES - 1);

   fmt_state_e   state_q;
   nib_cnt_t     nib_cnt_q;
   reg_id_t      reg_id_q;
   report_data_t data_q;    // Next digit sits at TOP_BIT
   nibble_t      cur_nib;
   logic         rep_take;
   logic         chr_take;

   function automatic char_t nib2ascii(input nibble_t nib);
      if (nib < 4'd10)
         return ASCII_0 + char_t'(nib);
      else
         return ASCII_A + char_t'(nib - 4'd10);
   endfunction

   assign o_idle = (state_q == FMT_IDLE);
   assign o_rep_ready = o_idle;    // One report at a time
   assign o_chr_valid = !o_idle;

   assign rep_take = i_rep_valid && o_rep_ready;
   assign chr_take = o_chr_valid && i_chr_ready;

   assign cur_nib = data_q[TOP_BIT -: 4];

   always_comb
   begin
      case (state_q)
         FMT_R:     o_chr = ASCII_R;
         FMT_ID:    o_chr = nib2ascii({2'b00, reg_id_q});
         FMT_COLON: o_chr = ASCII_COLON;
         FMT_HEX:   o_chr = nib2ascii(cur_nib);
         FMT_LF:    o_chr = ASCII_LF;
         FMT_CR:    o_chr = ASCII_CR;
         default:   o_chr = ASCII_CR;    // Not valid in idle
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= FMT_IDLE;
         nib_cnt_q <= '0;
      end
      else if (rep_take)
      begin
         state_q <= FMT_R;
         nib_cnt_q <= NIB_FIRST;
      end
      else if (chr_take)
      begin
         case (state_q)
            FMT_R:     state_q <= FMT_ID;
            FMT_ID:    state_q <= FMT_COLON;
            FMT_COLON: state_q <= FMT_HEX;
            FMT_HEX:
            begin
               if (nib_cnt_q == '0)
                  state_q <= FMT_LF;
               else
                  nib_cnt_q <= nib_cnt_q - 1'b1;
            end
            FMT_LF:    state_q <= FMT_CR;
            FMT_CR:    state_q <= FMT_IDLE;
            default:   state_q <= FMT_IDLE;
         endcase
      end
   end

   // Report payload shifted one digit per hex character
   always_ff @(posedge clk)
   begin
      if (rep_take)
      begin
         reg_id_q <= i_rep.reg_id;
         data_q <= i_rep.data;
      end
      else if (chr_take && state_q == FMT_HEX)
      begin
         data_q <= data_q << 4;
      end
   end

endmodule

// File: logic/char_fifo.sv
`timescale 1ns/1ps

module char_fifo
   import report_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  logic  clk,
   input  logic  rst,
   input  char_t i_wr_data,
   input  logic  i_wr_valid,
   output logic  o_wr_ready,
   output char_t o_rd_data,
   output logic  o_rd_valid,
   input  logic  i_rd_ready
);

   localparam int AW = $clog2(FIFO_DEPTH);

   // Extra MSB tells full from empty
   typedef logic [AW:0] ptr_t;

   char_t mem [FIFO_DEPTH];
   ptr_t  wr_ptr_q;
   ptr_t  rd_ptr_q;
   logic  full;
   logic  empty;
   logic  do_wr;
   logic  do_rd;

   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full = (wr_ptr_q[AW] != rd_ptr_q[AW])
              && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

   assign o_wr_ready = !full;
   assign o_rd_valid = !empty;
   assign o_rd_data = mem[rd_ptr_q[AW-1:0]];   // Head entry

   assign do_wr = i_wr_valid && !full;
   assign do_rd = i_rd_ready && !empty;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr_q[AW-1:0]] <= i_wr_data;
   end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic  clk,
   input  logic  rst,
   input  byte_t i_byte,
   input  logic  i_valid,
   output logic  o_ready,
   output logic  o_tx
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

   typedef logic [CNT_W-1:0] baud_cnt_t;

   localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);

   ser_state_e state_q;
   baud_cnt_t  baud_q;
   bit_idx_t   bit_q;
   byte_t      shift_q;    // LSB is the bit on the line
   logic       tx_q;
   logic       accept;
   logic       bit_end;

   assign o_ready = (state_q == SER_IDLE);
   assign o_tx = tx_q;
   assign accept = i_valid && o_ready;
   assign bit_end = (baud_q == BAUD_LAST);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= SER_IDLE;
         baud_q <= '0;
         bit_q <= '0;
         tx_q <= LINE_IDLE;
      end
      else if (state_q == SER_IDLE)
      begin
         baud_q <= '0;
         if (accept)
         begin
            state_q <= SER_START;
            tx_q <= START_LEVEL;   // Start bit from the next cycle
         end
      end
      else if (!bit_end)
      begin
         baud_q <= baud_q + 1'b1;
      end
      else
      begin
         baud_q <= '0;
         case (state_q)
            SER_START:
            begin
               state_q <= SER_DATA;
               bit_q <= '0;
               tx_q <= shift_q[0];
            end
            SER_DATA:
            begin
               if (bit_q == LAST_BIT)
               begin
                  state_q <= SER_STOP;
                  tx_q <= STOP_LEVEL;
               end
               else
               begin
                  bit_q <= bit_q + 1'b1;
                  tx_q <= shift_q[1];
               end
            end
            default:
            begin
               state_q <= SER_IDLE;    // Stop bit done
               tx_q <= LINE_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         shift_q <= i_byte;
      else if (state_q == SER_DATA && bit_end)
         shift_q <= shift_q >> 1;
   end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  i_rx,
   output byte_t o_data,
   output logic  o_valid,
   output logic  o_error
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam int HALF = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

   typedef logic [CNT_W-1:0] baud_cnt_t;

   localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
   localparam baud_cnt_t HALF_LAST = baud_cnt_t'(HALF - 1);

   logic       rx_meta_q;
   logic       rx_sync_q;
   logic       rx_prev_q;   // For the falling edge
   ser_state_e state_q;
   baud_cnt_t  baud_q;
   bit_idx_t   bit_q;
   byte_t      shift_q;
   logic       valid_q;
   logic       error_q;
   logic       fall;
   logic       sample;

   assign fall = rx_prev_q && !rx_sync_q;
   assign o_data = shift_q;
   assign o_valid = valid_q;
   assign o_error = error_q;

   // Bit center reached
   assign sample = (state_q == SER_START) ? (baud_q == HALF_LAST) : (baud_q == BAUD_LAST);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_meta_q <= LINE_IDLE;
         rx_sync_q <= LINE_IDLE;
         rx_prev_q <= LINE_IDLE;
      end
      else
      begin
         rx_meta_q <= i_rx;
         rx_sync_q <= rx_meta_q;
         rx_prev_q <= rx_sync_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= SER_IDLE;
         baud_q <= '0;
         bit_q <= '0;
         valid_q <= 1'b0;
         error_q <= 1'b0;
      end
      else
      begin
         valid_q <= 1'b0;    // Pulses last one cycle
         error_q <= 1'b0;
         if (state_q == SER_IDLE)
         begin
            baud_q <= '0;
            if (fall)
               state_q <= SER_START;
         end
         else if (!sample)
         begin
            baud_q <= baud_q + 1'b1;
         end
         else
         begin
            baud_q <= '0;
            case (state_q)
               SER_START:
               begin
                  // Glitch if the line is back high
                  if (rx_sync_q == START_LEVEL)
                  begin
                     state_q <= SER_DATA;
                     bit_q <= '0;
                  end
                  else
                     state_q <= SER_IDLE;
               end
               SER_DATA:
               begin
                  if (bit_q == LAST_BIT)
                     state_q <= SER_STOP;
                  else
                     bit_q <= bit_q + 1'b1;
               end
               default:
               begin
                  state_q <= SER_IDLE;
                  if (rx_sync_q == STOP_LEVEL)
                     valid_q <= 1'b1;
                  else
                     error_q <= 1'b1;
               end
            endcase
         end
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk)
   begin
      if (state_q == SER_DATA && sample)
         shift_q <= {rx_sync_q, shift_q[7:1]};
   end

endmodule

// File: logic/uart_report_top.sv
`timescale 1ns/1ps

module uart_report_top
   import uart_pkg::*;
   import report_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16,
   parameter int NUM_NIBBLES = 4,
   parameter int FIFO_DEPTH = 16
) (
   input  logic    clk,
   input  logic    rst,
   input  report_t i_rep,
   input  logic    i_rep_valid,
   output logic    o_rep_ready,
   output logic    o_tx,
   output logic    o_busy,
   input  logic    i_rx,
   output byte_t   o_rx_data,
   output logic    o_rx_valid,
   output logic    o_rx_error
);

   char_t chr;
   logic  chr_valid;
   logic  chr_ready;
   byte_t tx_byte;
   logic  tx_valid;
   logic  tx_ready;
   logic  fmt_idle;

   report_formatter #(
      .NUM_NIBBLES (NUM_NIBBLES)
   ) u_formatter (
      .clk         (clk),
      .rst         (rst),
      .i_rep       (i_rep),
      .i_rep_valid (i_rep_valid),
      .o_rep_ready (o_rep_ready),
      .o_chr       (chr),
      .o_chr_valid (chr_valid),
      .i_chr_ready (chr_ready),
      .o_idle      (fmt_idle)
   );

   // Holds a whole line while the serial side drains
   char_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk        (clk),
      .rst        (rst),
      .i_wr_data  (chr),
      .i_wr_valid (chr_valid),
      .o_wr_ready (chr_ready),
      .o_rd_data  (tx_byte),
      .o_rd_valid (tx_valid),
      .i_rd_ready (tx_ready)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_tx (
      .clk     (clk),
      .rst     (rst),
      .i_byte  (tx_byte),
      .i_valid (tx_valid),
      .o_ready (tx_ready),
      .o_tx    (o_tx)
   );

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_rx (
      .clk     (clk),
      .rst     (rst),
      .i_rx    (i_rx),
      .o_data  (o_rx_data),
      .o_valid (o_rx_valid),
      .o_error (o_rx_error)
   );

   assign o_busy = !fmt_idle || tx_valid || !tx_ready;   // Any stage still working

endmodule

// File: testbench/tb_serial_tasks.svh
`ifndef TB_SERIAL_TASKS_SVH
`define TB_SERIAL_TASKS_SVH

// Drives one frame on i_rx LSB first with bit changes on falling clock edges
task automatic send_frame(input byte_t data, input logic bad_stop);
   logic [FRAME_BITS-1:0] bits;
   bits = {!bad_stop, data, START_LEVEL};
   for (int i = 0; i < FRAME_BITS; i++)
   begin
      @(negedge clk);
      i_rx = bits[i];
      repeat (CLKS_PER_BIT - 1)
         @(negedge clk);
   end
   @(negedge clk);
   i_rx = LINE_IDLE;
   repeat (CLKS_PER_BIT)    // One idle bit between frames
      @(negedge clk);
endtask

// Decodes every frame on o_tx by sampling near the bit centers
task automatic decode_tx_frames();
   byte_t data;
   forever
   begin
      @(negedge o_tx);
      repeat (CLKS_PER_BIT / 2)
         @(negedge clk);
      assert (o_tx == START_LEVEL) else
      begin
         $display("Start bit on o_tx did not stay low at %0t", $time);
         errors++;
      end
      for (int i = 0; i < 8; i++)
      begin
         repeat (CLKS_PER_BIT)
            @(negedge clk);
         data[i] = o_tx;
      end
      repeat (CLKS_PER_BIT)
         @(negedge clk);
      assert (o_tx == STOP_LEVEL) else
      begin
         $display("Frame on o_tx has a low stop bit at %0t", $time);
         errors++;
      end
      tx_got_q.push_back(data);
   end
endtask

`endif

// File: testbench/tb_uart_report.sv
`timescale 1ns/1ps

module tb_uart_report
   import uart_pkg::*;
   import report_pkg::*;
();

   localparam int CLKS_PER_BIT = 8;
   localparam int NUM_NIBBLES = 4;
   localparam int LINE_LEN = 5 + NUM_NIBBLES;
   localparam int N_BURST = 20;
   localparam int N_RX = 30;
   localparam int N_DUPLEX_REP = 8;
   localparam int N_DUPLEX_RX = 12;
   // All TX characters and RX bytes of the run
   localparam int TOTAL_CHARS = (1 + N_BURST + N_DUPLEX_REP) * LINE_LEN
                              + N_RX + 2 + N_DUPLEX_RX;
   localparam int CYCLE_LIMIT = TOTAL_CHARS * FRAME_BITS * CLKS_PER_BIT * 2 + 2000;

   logic    clk;
   logic    rst;
   report_t i_rep;
   logic    i_rep_valid;
   logic    o_rep_ready;
   logic    o_tx;
   logic    o_busy;
   logic    i_rx;
   byte_t   o_rx_data;
   logic    o_rx_valid;
   logic    o_rx_error;

   char_t       exp_tx_q[$];
   byte_t       tx_got_q[$];
   byte_t       exp_rx_q[$];
   byte_t       rx_exp;
   logic [31:0] rng_state = 32'h43e7;
   int          errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          rx_err_cnt = 0;
   int          line_chars = LINE_LEN;   // Characters since the last report handshake
   int          cycle_cnt = 0;

   uart_report_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .NUM_NIBBLES  (NUM_NIBBLES),
      .FIFO_DEPTH   (16)
   ) u_dut (
      .clk         (clk),
      .rst         (rst),
      .i_rep       (i_rep),
      .i_rep_valid (i_rep_valid),
      .o_rep_ready (o_rep_ready),
      .o_tx        (o_tx),
      .o_busy      (o_busy),
      .i_rx        (i_rx),
      .o_rx_data   (o_rx_data),
      .o_rx_valid  (o_rx_valid),
      .o_rx_error  (o_rx_error)
   );

   always #20 clk = ~clk;

   `include "tb_serial_tasks.svh"

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic report_t random_report();
      report_t rep;
      rep.data = next_random();
      rep.reg_id = reg_id_t'(next_random());
      return rep;
   endfunction

   function automatic char_t hex_char(input logic [3:0] value);
      string digits;
      digits = "0123456789ABCDEF";
      return digits[value];
   endfunction

   // Reference line of R, ID digit, colon, low nibbles MSB first, LF and CR
   function automatic void expected_line(input report_t rep);
      exp_tx_q.push_back("R");
      exp_tx_q.push_back(hex_char({2'b00, rep.reg_id}));
      exp_tx_q.push_back(":");
      for (int n = NUM_NIBBLES - 1; n >= 0; n--)
         exp_tx_q.push_back(hex_char(rep.data[4*n +: 4]));
      exp_tx_q.push_back(8'h0A);
      exp_tx_q.push_back(8'h0D);
   endfunction

   task automatic offer_report(input report_t rep);
      @(negedge clk);
      i_rep = rep;
      i_rep_valid = 1'b1;
      while (!o_rep_ready)
         @(negedge clk);
      expected_line(rep);   // Taken on the coming rising edge
   endtask

   task automatic send_expected_byte(input byte_t data);
      exp_rx_q.push_back(data);
      send_frame(data, 1'b0);
   endtask

   task automatic wait_tx_drained();
      @(negedge clk);
      while (exp_tx_q.size() != 0 || o_busy)
         @(negedge clk);
   endtask

   task automatic check_rx_drained(input int err_base);
      repeat (CLKS_PER_BIT)
         @(negedge clk);
      assert (exp_rx_q.size() == 0 && rx_err_cnt == err_base) else
      begin
         $display("RX path lost %0d bytes or flagged %0d framing errors",
                  exp_rx_q.size(), rx_err_cnt - err_base);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (errors == errs_before)
      begin
         tests_passed++;
         $display("Test %s: passed", name);
      end
      else
      begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", name, errors - errs_before);
      end
   endtask

   // Compares decoded TX characters in order
   initial
   begin
      byte_t got;
      forever
      begin
         @(negedge clk);
         while (tx_got_q.size() > 0)
         begin
            got = tx_got_q.pop_front();
            assert (exp_tx_q.size() > 0) else
            begin
               $display("Unexpected character 0x%02h on o_tx at %0t", got, $time);
               errors++;
            end
            if (exp_tx_q.size() > 0)
            begin
               assert (got == exp_tx_q[0]) else
               begin
                  $display("Fail %0t: o_tx sent 0x%02h, expected 0x%02h",
                           $time, got, exp_tx_q[0]);
                  errors++;
               end
               void'(exp_tx_q.pop_front());
            end
         end
      end
   end

   always @(negedge clk)
   begin
      if (o_rx_error)
         rx_err_cnt++;
      if (o_rx_valid)
      begin
         assert (exp_rx_q.size() > 0) else
         begin
            $display("Unexpected byte 0x%02h on o_rx_data at %0t", o_rx_data, $time);
            errors++;
         end
         if (exp_rx_q.size() > 0)
         begin
            rx_exp = exp_rx_q.pop_front();
            assert (o_rx_data == rx_exp) else
            begin
               $display("Fail %0t: o_rx_data 0x%02h, expected 0x%02h", $time, o_rx_data, rx_exp);
               errors++;
            end
         end
      end
   end

   // No new report may be accepted before the whole line is out
   always @(posedge clk)
   begin
      if (rst)
         line_chars = LINE_LEN;
      else
      begin
         if (u_dut.chr_valid && u_dut.chr_ready)
            line_chars++;
         if (o_rep_ready)
         begin
            assert (line_chars >= LINE_LEN) else
            begin
               $display("Fail %0t: o_rep_ready high after %0d characters", $time, line_chars);
               errors++;
            end
         end
         if (o_rep_ready && i_rep_valid)
            line_chars = 0;
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT)
      begin
         $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial
   begin
      int    errs;
      int    err_base;
      byte_t rx_bytes[$];
      clk = 1'b0;
      rst = 1'b1;
      i_rep = '0;
      i_rep_valid = 1'b0;
      i_rx = LINE_IDLE;
      repeat (2)
         @(negedge clk);
      rst = 1'b0;
      fork
         decode_tx_frames();
      join_none

      errs = errors;
      assert (o_tx && !o_busy && !o_rx_valid && !o_rx_error && o_rep_ready) else
      begin
         $display("Fail %0t: after reset tx=%b busy=%b rx_valid=%b rx_error=%b rep_ready=%b",
                  $time, o_tx, o_busy, o_rx_valid, o_rx_error, o_rep_ready);
         errors++;
      end
      for (int i = 0; i < 50; i++)
      begin
         @(negedge clk);
         assert (o_tx == LINE_IDLE) else
         begin
            $display("Fail %0t: o_tx left the idle level while the DUT was idle", $time);
            errors++;
         end
      end
      finish_test("reset state", errs);

      errs = errors;
      offer_report({2'd2, 32'h1234ABCD});
      @(negedge clk);
      i_rep_valid = 1'b0;
      wait_tx_drained();
      finish_test("single report", errs);

      errs = errors;
      for (int i = 0; i < N_BURST; i++)
         offer_report(random_report());
      @(negedge clk);
      i_rep_valid = 1'b0;
      wait_tx_drained();
      finish_test("back-to-back reports", errs);

      errs = errors;
      err_base = rx_err_cnt;
      for (int i = 0; i < N_RX; i++)
         send_expected_byte(byte_t'(next_random()));
      check_rx_drained(err_base);
      finish_test("receive path", errs);

      errs = errors;
      err_base = rx_err_cnt;
      send_frame(byte_t'(next_random()), 1'b1);
      assert (rx_err_cnt == err_base + 1) else
      begin
         $display("Fail %0t: %0d framing errors, expected 1", $time, rx_err_cnt - err_base);
         errors++;
      end
      send_expected_byte(byte_t'(next_random()));
      check_rx_drained(err_base + 1);
      finish_test("framing error", errs);

      errs = errors;
      err_base = rx_err_cnt;
      for (int i = 0; i < N_DUPLEX_RX; i++)
         rx_bytes.push_back(byte_t'(next_random()));
      fork
         begin
            for (int i = 0; i < N_DUPLEX_REP; i++)
               offer_report(random_report());
            @(negedge clk);
            i_rep_valid = 1'b0;
         end
         begin
            for (int k = 0; k < N_DUPLEX_RX; k++)
               send_expected_byte(rx_bytes[k]);
         end
      join
      wait_tx_drained();
      check_rx_drained(err_base);
      finish_test("full duplex", errs);

      $display("Tests passed: %0d, failed: %0d, check errors: %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: sources.f
+incdir+testbench
logic/uart_pkg.sv
logic/report_pkg.sv
logic/report_formatter.sv
logic/char_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_report_top.sv
testbench/tb_uart_report.sv

// File: Bender.yml
package:
  name: uart_report

sources:
  - logic/uart_pkg.sv
  - logic/report_pkg.sv
  - logic/report_formatter.sv
  - logic/char_fifo.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/uart_report_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_uart_report.sv
